//--- include/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// power-of-two data RAM depth in 32-bit words.
`define LSU_RAM_WORDS 256

// idle cycles with req high before the RAM accepts a beat.
`define LSU_RAM_WAIT_CYCLES 1

// extra cycles on top of the computed testbench timeout.
`define LSU_TIMEOUT_MARGIN 64

`endif

//--- rtl/lsu_pkg.sv
package lsu_pkg;

    // width of a load access.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'h0,
        SIZE_HALF = 2'h1,
        SIZE_WORD = 2'h2
    } access_size_t;

    // one memory word, seen whole or as four byte lanes.
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } mem_word_t;

    // current owner of the shared memory port.
    typedef enum logic [1:0] {
        GRANT_NONE  = 2'h0,
        GRANT_STORE = 2'h1,
        GRANT_LOAD  = 2'h2
    } grant_t;

endpackage

//--- rtl/mem_port_if.sv
interface mem_port_if (
    input logic reset_n
);

    logic        req;
    logic        write;
    logic [31:0] addr;
    logic [31:0] write_data;
    logic [3:0]  byte_enable;
    logic        ready;
    logic [31:0] read_data;

    modport requester (
        output req,
        output write,
        output addr,
        output write_data,
        output byte_enable,
        input  ready,
        input  read_data
    );

    modport memory (
        input  reset_n,
        input  req,
        input  write,
        input  addr,
        input  write_data,
        input  byte_enable,
        output ready,
        output read_data
    );

endinterface

//--- rtl/store_unit.sv
module store_unit (
    input  logic        clk,
    input  logic        reset_n,
    output logic        write_ready,
    input  logic        write_req,
    input  logic [31:0] write_addr,
    input  logic [31:0] write_data,
    input  logic [3:0]  write_byte_enable,
    mem_port_if.requester mem
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STORE_LOW,
        ST_STORE_HIGH
    } state_t;

    state_t state;
    state_t state_next;

    logic        req_q;
    logic        req_next;
    logic [31:0] addr_q;
    logic [31:0] addr_next;
    logic [31:0] data_q;
    logic [31:0] data_next;
    logic [3:0]  be_q;
    logic [3:0]  be_next;

    // store data and enables placed across two words.
    logic [63:0] window;
    logic [63:0] window_next;
    logic [7:0]  window_be;
    logic [7:0]  window_be_next;

    assign write_ready     = state == ST_IDLE;
    assign mem.req         = req_q;
    assign mem.write       = 1'b1;
    assign mem.addr        = addr_q;
    assign mem.write_data  = data_q;
    assign mem.byte_enable = be_q;

    always_comb begin
        state_next     = state;
        req_next       = req_q;
        addr_next      = addr_q;
        data_next      = data_q;
        be_next        = be_q;
        window_next    = window;
        window_be_next = window_be;

        case (state)
            ST_IDLE: begin
                if (write_req) begin
                    window_next    = {32'h0, write_data} << {write_addr[1:0], 3'h0};
                    window_be_next = {4'h0, write_byte_enable} << write_addr[1:0];
                    addr_next      = {write_addr[31:2], 2'h0};
                    data_next      = window_next[31:0];
                    be_next        = window_be_next[3:0];
                    req_next       = 1'b1;
                    state_next     = ST_STORE_LOW;
                end
            end
            ST_STORE_LOW: begin
                if (mem.ready) begin
                    if (window_be[7:4] == 4'h0) begin
                        req_next   = 1'b0;
                        state_next = ST_IDLE;
                    end else begin
                        // second beat at the following word.
                        addr_next  = {addr_q[31:2] + 30'h1, 2'h0};
                        data_next  = window[63:32];
                        be_next    = window_be[7:4];
                        state_next = ST_STORE_HIGH;
                    end
                end
            end
            ST_STORE_HIGH: begin
                if (mem.ready) begin
                    req_next   = 1'b0;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                req_next   = 1'b0;
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
            req_q <= 1'b0;
        end else begin
            state <= state_next;
            req_q <= req_next;
        end
    end

    always_ff @(posedge clk) begin
        addr_q    <= addr_next;
        data_q    <= data_next;
        be_q      <= be_next;
        window    <= window_next;
        window_be <= window_be_next;
    end

    // a beat holds its request until the memory accepts it.
    a_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
        mem.req && !mem.ready |=> mem.req && $stable(mem.addr));

endmodule

//--- rtl/load_unit.sv
module load_unit
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    output logic         read_ready,
    input  logic         read_req,
    input  logic [31:0]  read_addr,
    input  access_size_t read_size,
    input  logic         read_signed,
    output logic         read_valid,
    output logic [31:0]  read_data,
    mem_port_if.requester mem
);

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_LOAD_LOW,
        LD_LOAD_HIGH
    } state_t;

    state_t state;
    state_t state_next;

    logic         req_q;
    logic         req_next;
    logic         valid_next;
    logic [31:0]  data_next;
    logic [31:0]  addr_q;
    logic [31:0]  addr_next;
    logic [1:0]   offset_q;
    logic [1:0]   offset_next;
    access_size_t size_q;
    access_size_t size_next;
    logic         signed_q;
    logic         signed_next;
    logic [31:0]  low_q;
    logic [31:0]  low_next;

    logic [2:0]   byte_count;
    logic         needs_high;
    mem_word_t    lo_word;
    mem_word_t    hi_word;
    logic [7:0]   picked [4];
    logic [31:0]  result;

    assign read_ready      = state == LD_IDLE;
    assign mem.req         = req_q;
    assign mem.write       = 1'b0;
    assign mem.addr        = addr_q;
    assign mem.write_data  = 32'h0;
    assign mem.byte_enable = 4'hf;

    always_comb begin
        case (size_q)
            SIZE_BYTE: byte_count = 3'd1;
            SIZE_HALF: byte_count = 3'd2;
            default:   byte_count = 3'd4;
        endcase
    end

    assign needs_high = ({1'b0, offset_q} + byte_count) > 3'd4;

    // the low word is still on the bus during the first beat.
    assign lo_word.word = (state == LD_LOAD_LOW) ? mem.read_data : low_q;
    assign hi_word.word = mem.read_data;

    always_comb begin : collect
        logic [2:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx = {1'b0, offset_q} + 3'(i);
            picked[i] = idx[2] ? hi_word.lanes[idx[1:0]] : lo_word.lanes[idx[1:0]];
        end
    end

    always_comb begin
        case (size_q)
            SIZE_BYTE: result = {{24{signed_q & picked[0][7]}}, picked[0]};
            SIZE_HALF: result = {{16{signed_q & picked[1][7]}}, picked[1], picked[0]};
            default:   result = {picked[3], picked[2], picked[1], picked[0]};
        endcase
    end

    always_comb begin
        state_next  = state;
        req_next    = req_q;
        valid_next  = 1'b0;
        data_next   = read_data;
        addr_next   = addr_q;
        offset_next = offset_q;
        size_next   = size_q;
        signed_next = signed_q;
        low_next    = low_q;

        case (state)
            LD_IDLE: begin
                if (read_req) begin
                    addr_next   = {read_addr[31:2], 2'h0};
                    offset_next = read_addr[1:0];
                    size_next   = read_size;
                    signed_next = read_signed;
                    req_next    = 1'b1;
                    state_next  = LD_LOAD_LOW;
                end
            end
            LD_LOAD_LOW: begin
                if (mem.ready) begin
                    low_next = mem.read_data;
                    if (needs_high) begin
                        addr_next  = {addr_q[31:2] + 30'h1, 2'h0};
                        state_next = LD_LOAD_HIGH;
                    end else begin
                        req_next   = 1'b0;
                        valid_next = 1'b1;
                        data_next  = result;
                        state_next = LD_IDLE;
                    end
                end
            end
            LD_LOAD_HIGH: begin
                if (mem.ready) begin
                    req_next   = 1'b0;
                    valid_next = 1'b1;
                    data_next  = result;
                    state_next = LD_IDLE;
                end
            end
            default: begin
                req_next   = 1'b0;
                state_next = LD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= LD_IDLE;
            req_q      <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            state      <= state_next;
            req_q      <= req_next;
            read_valid <= valid_next;
        end
    end

    always_ff @(posedge clk) begin
        read_data <= data_next;
        addr_q    <= addr_next;
        offset_q  <= offset_next;
        size_q    <= size_next;
        signed_q  <= signed_next;
        low_q     <= low_next;
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
        mem.req && !mem.ready |=> mem.req && $stable(mem.addr));

    // one pulse per completed load.
    a_valid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        read_valid |=> !read_valid);

endmodule

//--- rtl/mem_arbiter.sv
module mem_arbiter
    import lsu_pkg::*;
(
    input logic clk,
    input logic reset_n,
    mem_port_if.memory    store_port,
    mem_port_if.memory    load_port,
    mem_port_if.requester ram_port
);

    grant_t grant;
    grant_t owner;

    // the holder keeps the port while its req stays high.
    // a free port goes to the store first.
    always_comb begin
        if (grant == GRANT_STORE && store_port.req) begin
            owner = GRANT_STORE;
        end else if (grant == GRANT_LOAD && load_port.req) begin
            owner = GRANT_LOAD;
        end else if (store_port.req) begin
            owner = GRANT_STORE;
        end else if (load_port.req) begin
            owner = GRANT_LOAD;
        end else begin
            owner = GRANT_NONE;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grant <= GRANT_NONE;
        end else begin
            grant <= owner;
        end
    end

    assign ram_port.req         = owner != GRANT_NONE;
    assign ram_port.write       = (owner == GRANT_STORE) ? store_port.write : load_port.write;
    assign ram_port.addr        = (owner == GRANT_STORE) ? store_port.addr : load_port.addr;
    assign ram_port.write_data  = (owner == GRANT_STORE) ? store_port.write_data
                                                         : load_port.write_data;
    assign ram_port.byte_enable = (owner == GRANT_STORE) ? store_port.byte_enable
                                                         : load_port.byte_enable;

    assign store_port.ready     = (owner == GRANT_STORE) && ram_port.ready;
    assign load_port.ready      = (owner == GRANT_LOAD) && ram_port.ready;
    assign store_port.read_data = ram_port.read_data;
    assign load_port.read_data  = ram_port.read_data;

    // a forwarded beat stays on the RAM port until the RAM accepts it.
    a_ram_hold: assert property (@(posedge clk) disable iff (!reset_n)
        ram_port.req && !ram_port.ready |=>
            ram_port.req && $stable(ram_port.addr) && $stable(ram_port.write));

endmodule

//--- rtl/data_ram.sv
`include "lsu_config.svh"

module data_ram
    import lsu_pkg::*;
(
    input logic clk,
    mem_port_if.memory mem
);

    localparam int WORDS = `LSU_RAM_WORDS;
    localparam int WAIT  = `LSU_RAM_WAIT_CYCLES;
    localparam int IW    = $clog2(WORDS);
    localparam int CW    = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

    mem_word_t ram [WORDS];

    logic [CW-1:0] wait_count;
    logic [IW-1:0] index;
    mem_word_t     current;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            ram[i] = '0;
        end
    end

    // word index wraps modulo the depth.
    assign index   = mem.addr[IW+1:2];
    assign current = ram[index];

    assign mem.ready     = mem.req && (wait_count == CW'(WAIT));
    assign mem.read_data = current.word;

    always_ff @(posedge clk or negedge mem.reset_n) begin
        if (!mem.reset_n) begin
            wait_count <= '0;
        end else if (!mem.req || mem.ready) begin
            wait_count <= '0;
        end else begin
            wait_count <= wait_count + 1'b1;
        end
    end

    // lane merge under the byte enables.
    always_ff @(posedge clk) begin
        if (mem.ready && mem.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mem.byte_enable[lane]) begin
                    ram[index].lanes[lane] <= mem.write_data[lane*8 +: 8];
                end
            end
        end
    end

endmodule

//--- rtl/load_store_unit.sv
module load_store_unit
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,

    output logic         write_ready,
    input  logic         write_req,
    input  logic [31:0]  write_addr,
    input  logic [31:0]  write_data,
    input  logic [3:0]   write_byte_enable,

    output logic         read_ready,
    input  logic         read_req,
    input  logic [31:0]  read_addr,
    input  access_size_t read_size,
    input  logic         read_signed,
    output logic         read_valid,
    output logic [31:0]  read_data
);

    mem_port_if store_bus (.reset_n(reset_n));
    mem_port_if load_bus  (.reset_n(reset_n));
    mem_port_if ram_bus   (.reset_n(reset_n));

    store_unit store_unit_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .write_ready       (write_ready),
        .write_req         (write_req),
        .write_addr        (write_addr),
        .write_data        (write_data),
        .write_byte_enable (write_byte_enable),
        .mem               (store_bus.requester)
    );

    load_unit load_unit_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_ready  (read_ready),
        .read_req    (read_req),
        .read_addr   (read_addr),
        .read_size   (read_size),
        .read_signed (read_signed),
        .read_valid  (read_valid),
        .read_data   (read_data),
        .mem         (load_bus.requester)
    );

    mem_arbiter mem_arbiter_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .store_port (store_bus.memory),
        .load_port  (load_bus.memory),
        .ram_port   (ram_bus.requester)
    );

    data_ram data_ram_inst (
        .clk (clk),
        .mem (ram_bus.memory)
    );

endmodule

//--- verification/clock_gen.sv
module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset is released on a rising edge after the hold count.
    initial begin
        reset_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

//--- verification/lsu_tb.sv
`include "lsu_config.svh"

module lsu_tb
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED        = 2455;
    localparam int WORDS       = `LSU_RAM_WORDS;
    localparam int WAIT_CYCLES = `LSU_RAM_WAIT_CYCLES;
    localparam int MEM_BYTES   = WORDS * 4;
    localparam int HALF_BYTES  = MEM_BYTES / 2;
    localparam int AW          = $clog2(MEM_BYTES);

    localparam int N_ALIGNED    = 16;
    localparam int N_MERGE      = 40;
    localparam int N_NARROW     = 4;
    localparam int N_UNALIGNED  = 24;
    localparam int N_WRAP_OPS   = 7;
    localparam int N_CONCURRENT = 12;
    localparam int N_BUSY       = 4;

    localparam int TOTAL_OPS = 2 * N_ALIGNED + 3 * N_MERGE + 18 * N_NARROW + N_UNALIGNED +
                               N_WRAP_OPS + 3 * N_CONCURRENT + 2 * N_BUSY;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 2 * (2 + WAIT_CYCLES) * 2 +
                                    `LSU_TIMEOUT_MARGIN;

    logic         clk;
    logic         reset_n;
    logic         write_ready;
    logic         write_req;
    logic [31:0]  write_addr;
    logic [31:0]  write_data;
    logic [3:0]   write_byte_enable;
    logic         read_ready;
    logic         read_req;
    logic [31:0]  read_addr;
    access_size_t read_size;
    logic         read_signed;
    logic         read_valid;
    logic [31:0]  read_data;

    // byte-wide image of the data RAM.
    logic [7:0] model [MEM_BYTES];

    int loads_done;
    int valid_pulses;
    int cycle_count;

    clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (2)
    ) clock_gen_inst (
        .clk     (clk),
        .reset_n (reset_n)
    );

    load_store_unit load_store_unit_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .write_ready       (write_ready),
        .write_req         (write_req),
        .write_addr        (write_addr),
        .write_data        (write_data),
        .write_byte_enable (write_byte_enable),
        .read_ready        (read_ready),
        .read_req          (read_req),
        .read_addr         (read_addr),
        .read_size         (read_size),
        .read_signed       (read_signed),
        .read_valid        (read_valid),
        .read_data         (read_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected %08h, actual %08h", name, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: the DUT did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    always @(negedge clk) begin
        if (reset_n && read_valid) begin
            valid_pulses <= valid_pulses + 1;
        end
    end

    function automatic int size_bytes(input access_size_t size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic access_size_t size_from_index(input logic [31:0] sel);
        case (sel)
            32'd0:   return SIZE_BYTE;
            32'd1:   return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    // truncating the byte address wraps it modulo the RAM size.
    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] be);
        logic [AW-1:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx = AW'(addr + 32'(i));
            if (be[i]) begin
                model[idx] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr, input access_size_t size,
                                               input logic sgn);
        logic [AW-1:0] idx;
        logic [7:0]    top;
        logic [31:0]   value;
        int            count;
        count = size_bytes(size);
        value = '0;
        top   = '0;
        for (int i = 0; i < count; i++) begin
            idx   = AW'(addr + 32'(i));
            top   = model[idx];
            value = value | (32'(top) << (8 * i));
        end
        if (sgn && top[7]) begin
            for (int i = count; i < 4; i++) begin
                value[8*i +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    // probe adds a conflicting request while the unit is busy.
    task automatic store_access(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] be, input logic probe);
        @(posedge clk);
        write_req         <= 1'b1;
        write_addr        <= addr;
        write_data        <= data;
        write_byte_enable <= be;
        @(posedge clk);
        if (probe) begin
            write_data        <= ~data;
            write_byte_enable <= 4'hf;
            @(posedge clk);
        end
        write_req <= 1'b0;
        @(negedge clk);
        while (!write_ready) @(negedge clk);
        model_write(addr, data, be);
    endtask

    task automatic load_access(input logic [31:0] addr, input access_size_t size,
                               input logic sgn, input logic probe, output logic [31:0] data);
        @(posedge clk);
        read_req    <= 1'b1;
        read_addr   <= addr;
        read_size   <= size;
        read_signed <= sgn;
        @(posedge clk);
        if (probe) begin
            read_addr   <= addr + 32'h44;
            read_size   <= SIZE_WORD;
            read_signed <= ~sgn;
            @(posedge clk);
        end
        read_req <= 1'b0;
        @(negedge clk);
        while (!read_valid) @(negedge clk);
        data = read_data;
        loads_done++;
    endtask

    task automatic load_and_check(input string name, input logic [31:0] addr,
                                  input access_size_t size, input logic sgn, input logic probe);
        logic [31:0] expected;
        logic [31:0] got;
        expected = model_read(addr, size, sgn);
        load_access(addr, size, sgn, probe, got);
        check_equal($sformatf("%s @%08h", name, addr), expected, got);
    endtask

    task automatic store_and_load_together(input logic [31:0] st_addr,
                                           input logic [31:0] st_data,
                                           input logic [31:0] ld_addr,
                                           input access_size_t ld_size, input logic ld_signed,
                                           input logic store_late,
                                           output logic [31:0] data);
        logic store_done;
        logic load_done;
        store_done = 1'b0;
        load_done  = 1'b0;
        data       = '0;
        @(posedge clk);
        read_req    <= 1'b1;
        read_addr   <= ld_addr;
        read_size   <= ld_size;
        read_signed <= ld_signed;
        if (!store_late) begin
            write_req         <= 1'b1;
            write_addr        <= st_addr;
            write_data        <= st_data;
            write_byte_enable <= 4'hf;
        end
        @(posedge clk);
        read_req <= 1'b0;
        // a late store arrives while the load holds the port.
        if (store_late) begin
            write_req         <= 1'b1;
            write_addr        <= st_addr;
            write_data        <= st_data;
            write_byte_enable <= 4'hf;
            @(posedge clk);
        end
        write_req <= 1'b0;
        while (!(store_done && load_done)) begin
            @(negedge clk);
            if (write_ready) begin
                store_done = 1'b1;
            end
            if (read_valid) begin
                load_done = 1'b1;
                data      = read_data;
            end
        end
        loads_done++;
    endtask

    task automatic check_pulse_count(input string name);
        repeat (3) @(posedge clk);
        check_equal(name, 32'(loads_done), 32'(valid_pulses));
    endtask

    task automatic write_then_read_aligned();
        logic [31:0] addr;
        for (int n = 0; n < N_ALIGNED; n++) begin
            addr = ($urandom % WORDS) << 2;
            store_access(addr, $urandom, 4'hf, 1'b0);
            load_and_check("aligned word", addr, SIZE_WORD, 1'b0, 1'b0);
        end
    endtask

    task automatic merge_random_bytes();
        logic [31:0] addr;
        logic [31:0] base;
        for (int n = 0; n < N_MERGE; n++) begin
            addr = $urandom % MEM_BYTES;
            base = addr & ~32'h3;
            store_access(addr, $urandom, 4'($urandom), 1'b0);
            load_and_check("merge low word", base, SIZE_WORD, 1'b0, 1'b0);
            load_and_check("merge high word", base + 32'h4, SIZE_WORD, 1'b0, 1'b0);
        end
    endtask

    task automatic sweep_narrow_loads();
        logic [31:0] base;
        logic [31:0] fill;
        for (int r = 0; r < N_NARROW; r++) begin
            base = ($urandom % (WORDS - 1)) << 2;
            // odd rounds force negative bytes.
            fill = (r % 2 == 1) ? 32'h8080_8080 : 32'h0;
            store_access(base, $urandom | fill, 4'hf, 1'b0);
            store_access(base + 32'h4, $urandom | fill, 4'hf, 1'b0);
            for (int off = 0; off < 4; off++) begin
                for (int sg = 0; sg < 2; sg++) begin
                    load_and_check("byte load", base + 32'(off), SIZE_BYTE, sg != 0, 1'b0);
                    load_and_check("half load", base + 32'(off), SIZE_HALF, sg != 0, 1'b0);
                end
            end
        end
    endtask

    task automatic read_unaligned_and_wrapped();
        logic [31:0] addr;
        logic [31:0] top;
        for (int n = 0; n < N_UNALIGNED; n++) begin
            addr = (($urandom % WORDS) << 2) | (32'h1 + ($urandom % 3));
            load_and_check("unaligned word", addr, SIZE_WORD, 1'b0, 1'b0);
        end
        top = 32'(MEM_BYTES - 2);
        store_access(top, $urandom | 32'h0080_0000, 4'hf, 1'b0);
        load_and_check("wrap word", top, SIZE_WORD, 1'b0, 1'b0);
        load_and_check("wrap half", 32'(MEM_BYTES - 1), SIZE_HALF, 1'b1, 1'b0);
        load_and_check("top byte", 32'(MEM_BYTES - 1), SIZE_BYTE, 1'b1, 1'b0);
        load_and_check("top word", 32'(MEM_BYTES - 3), SIZE_WORD, 1'b0, 1'b0);
        load_and_check("word at zero", 32'h0, SIZE_WORD, 1'b0, 1'b0);
        load_and_check("aliased word", 32'(6 * MEM_BYTES - 1), SIZE_WORD, 1'b0, 1'b0);
    endtask

    task automatic contend_for_port();
        logic [31:0]  st_addr;
        logic [31:0]  st_data;
        logic [31:0]  ld_addr;
        logic [31:0]  expected;
        logic [31:0]  got;
        access_size_t size;
        logic         sgn;
        for (int n = 0; n < N_CONCURRENT; n++) begin
            // the store stays in the lower half and the load in the upper half.
            st_addr  = $urandom % (HALF_BYTES - 8);
            st_data  = $urandom;
            ld_addr  = 32'(HALF_BYTES) + ($urandom % (HALF_BYTES - 8));
            size     = size_from_index($urandom % 3);
            sgn      = 1'($urandom);
            expected = model_read(ld_addr, size, sgn);
            store_and_load_together(st_addr, st_data, ld_addr, size, sgn, (n % 2) == 1, got);
            model_write(st_addr, st_data, 4'hf);
            check_equal($sformatf("concurrent load @%08h", ld_addr), expected, got);
            load_and_check("concurrent store", st_addr, SIZE_WORD, 1'b0, 1'b0);
        end
        check_pulse_count("concurrent valid pulses");
    endtask

    task automatic probe_busy_units();
        logic [31:0] addr;
        logic [3:0]  be;
        for (int n = 0; n < N_BUSY; n++) begin
            addr = $urandom % MEM_BYTES;
            be   = 4'($urandom) | 4'h1;
            store_access(addr, $urandom, be, 1'b1);
            load_and_check("load after busy store", addr, SIZE_WORD, 1'b0, 1'b1);
            check_pulse_count("busy valid pulses");
        end
    endtask

    initial begin
        void'($urandom(SEED));
        write_req         <= 1'b0;
        write_addr        <= '0;
        write_data        <= '0;
        write_byte_enable <= '0;
        read_req          <= 1'b0;
        read_addr         <= '0;
        read_size         <= SIZE_WORD;
        read_signed       <= 1'b0;
        loads_done        = 0;
        valid_pulses      <= 0;
        cycle_count       <= 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'h0;
        end

        wait (reset_n === 1'b1);
        @(negedge clk);
        check_equal("idle after reset", 32'h3, {29'h0, read_valid, write_ready, read_ready});

        write_then_read_aligned();
        merge_random_bytes();
        sweep_narrow_loads();
        read_unaligned_and_wrapped();
        contend_for_port();
        probe_busy_units();
        check_pulse_count("total valid pulses");

        $display("All checks passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
rtl/lsu_pkg.sv
rtl/mem_port_if.sv
rtl/store_unit.sv
rtl/load_unit.sv
rtl/mem_arbiter.sv
rtl/data_ram.sv
rtl/load_store_unit.sv
verification/clock_gen.sv
verification/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the load/store testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module lsu_tb \
    -f sources.f \
    -o lsu_sim
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

output=$(./obj_dir/lsu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
else
    echo "run_sim: pass message not found"
    exit 1
fi
